/* Makefile */
TOOL     = verilator
FLAGS    = --binary --assert --timing --timescale 1ns/1ps -j 0
TOP      = bypass_ctrl_tb
FILELIST = all.f
PASS_MSG = Done: no errors

.PHONY: sim clean

# Build, run and look for the pass line in the simulator output
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* all.f */
verilog/bypass_pkg.sv
verilog/stage_track.sv
verilog/operand_fwd.sv
verilog/stall_ctrl.sv
verilog/bypass_ctrl.sv
verification/bypass_ctrl_asserts.sv
verification/bypass_ctrl_tb.sv

/* verification/bypass_ctrl_asserts.sv */
`timescale 1ns/1ps

// Output properties of the bypass controller, bound onto every instance
module bypass_ctrl_asserts (
  input logic                             clk,
  input logic                             reset_i,
  input logic                             id_ready_i,
  input logic                             load_stall_i,
  input logic                             jalr_stall_i,
  input logic                             csr_stall_i,
  input logic                             wfi_stall_i,
  input logic [bypass_pkg::FWD_SEL_W-1:0] op_a_sel_i,
  input logic [bypass_pkg::FWD_SEL_W-1:0] op_b_sel_i
);

  logic any_stall;

  assign any_stall = load_stall_i || jalr_stall_i || csr_stall_i || wfi_stall_i;

  // ID hands over an instruction only when nothing holds it back
  ready_without_stall: assert property (@(posedge clk) disable iff (reset_i)
    id_ready_i |-> !any_stall)
    else $error("id_ready_o is high while a stall is active");

  // The all ones code has no source behind the operand mux
  sel_code_legal: assert property (@(posedge clk) disable iff (reset_i)
    (op_a_sel_i != {bypass_pkg::FWD_SEL_W{1'b1}}) &&
    (op_b_sel_i != {bypass_pkg::FWD_SEL_W{1'b1}}))
    else $error("operand forward select uses the unused code");

  wfi_blocks_id: assert property (@(posedge clk) disable iff (reset_i)
    wfi_stall_i |-> !id_ready_i)
    else $error("id_ready_o is high while a WFI sits in EX");

  // Both stages come out of reset empty, so nothing can stall yet
  idle_after_reset: assert property (@(posedge clk) $fell(reset_i) |-> !any_stall)
    else $error("a stall is active in the first cycle after reset");

endmodule

bind bypass_ctrl bypass_ctrl_asserts u_asserts (
  .clk          (clk),
  .reset_i      (reset_i),
  .id_ready_i   (id_ready_o),
  .load_stall_i (load_stall_o),
  .jalr_stall_i (jalr_stall_o),
  .csr_stall_i  (csr_stall_o),
  .wfi_stall_i  (wfi_stall_o),
  .op_a_sel_i   (op_a_sel_o),
  .op_b_sel_i   (op_b_sel_o)
);

/* verification/bypass_ctrl_tb.sv */
`timescale 1ns/1ps

// Self-checking testbench for the hazard and bypass controller
// Random ID traffic runs against a cycle model of the EX and WB stages
module bypass_ctrl_tb;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 16;
  localparam int TEST_CYCLES  = 2000;
  // Twice the nominal run length in ns
  localparam int WATCHDOG_NS  = 2 * (RESET_CYCLES + TEST_CYCLES) * CLK_PERIOD;

  logic                                  clk;
  logic                                  reset_i;
  logic                                  id_valid_i;
  logic [bypass_pkg::NUM_READ_PORTS-1:0] rf_re_i;
  logic [bypass_pkg::REG_ADDR_W-1:0]     rf_raddr_a_i;
  logic [bypass_pkg::REG_ADDR_W-1:0]     rf_raddr_b_i;
  logic                                  id_rf_we_i;
  logic [bypass_pkg::REG_ADDR_W-1:0]     id_rf_waddr_i;
  logic                                  id_lsu_en_i;
  logic                                  id_jalr_i;
  logic                                  id_csr_en_i;
  logic                                  id_wfi_i;
  logic                                  wb_ready_i;
  logic                                  id_ready_o;
  logic                                  load_stall_o;
  logic                                  jalr_stall_o;
  logic                                  csr_stall_o;
  logic                                  wfi_stall_o;
  logic [bypass_pkg::FWD_SEL_W-1:0]      op_a_sel_o;
  logic [bypass_pkg::FWD_SEL_W-1:0]      op_b_sel_o;
  logic                                  jalr_sel_o;

  // Model copies of the EX and WB descriptors
  logic                              ref_ex_valid;
  logic                              ref_ex_we;
  logic [bypass_pkg::REG_ADDR_W-1:0] ref_ex_waddr;
  logic                              ref_ex_lsu;
  logic                              ref_ex_csr;
  logic                              ref_ex_wfi;
  logic                              ref_wb_valid;
  logic                              ref_wb_we;
  logic [bypass_pkg::REG_ADDR_W-1:0] ref_wb_waddr;
  logic                              ref_wb_lsu;
  logic                              ref_wb_csr;

  // Expected outputs for the current cycle
  logic                             exp_id_ready;
  logic                             exp_load_stall;
  logic                             exp_jalr_stall;
  logic                             exp_csr_stall;
  logic                             exp_wfi_stall;
  logic [bypass_pkg::FWD_SEL_W-1:0] exp_op_a_sel;
  logic [bypass_pkg::FWD_SEL_W-1:0] exp_op_b_sel;
  logic                             exp_jalr_sel;

  logic [31:0] rng_state;
  int unsigned fail_count;
  int unsigned accept_count;
  int unsigned stall_count;

  bypass_ctrl DUT (
    .clk           (clk),
    .reset_i       (reset_i),
    .id_valid_i    (id_valid_i),
    .rf_re_i       (rf_re_i),
    .rf_raddr_a_i  (rf_raddr_a_i),
    .rf_raddr_b_i  (rf_raddr_b_i),
    .id_rf_we_i    (id_rf_we_i),
    .id_rf_waddr_i (id_rf_waddr_i),
    .id_lsu_en_i   (id_lsu_en_i),
    .id_jalr_i     (id_jalr_i),
    .id_csr_en_i   (id_csr_en_i),
    .id_wfi_i      (id_wfi_i),
    .wb_ready_i    (wb_ready_i),
    .id_ready_o    (id_ready_o),
    .load_stall_o  (load_stall_o),
    .jalr_stall_o  (jalr_stall_o),
    .csr_stall_o   (csr_stall_o),
    .wfi_stall_o   (wfi_stall_o),
    .op_a_sel_o    (op_a_sel_o),
    .op_b_sel_o    (op_b_sel_o),
    .jalr_sel_o    (jalr_sel_o)
  );

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Only x0 to x3 are used, so producers and consumers collide often
  function automatic logic [bypass_pkg::REG_ADDR_W-1:0] small_addr(input logic [1:0] a);
    logic [bypass_pkg::REG_ADDR_W-1:0] addr;
    addr      = '0;
    addr[1:0] = a;
    return addr;
  endfunction

  task automatic end_with_failure();
    $display("Done: errors found");
    $fatal(1, "simulation stopped after a failure");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
      fail_count++;
      end_with_failure();
    end
  endtask

  task automatic check_sel(input string name, input logic [bypass_pkg::FWD_SEL_W-1:0] got,
                           input logic [bypass_pkg::FWD_SEL_W-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
      fail_count++;
      end_with_failure();
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  // Applies the match, priority and stall rules to the model descriptors
  task automatic compute_expected();
    logic ex_wr;
    logic wb_wr;
    logic live_a;
    logic live_b;
    logic mex_a;
    logic mex_b;
    logic mwb_a;
    logic mwb_b;
    logic jalr_wb;
    ex_wr   = ref_ex_valid && ref_ex_we;
    wb_wr   = ref_wb_valid && ref_wb_we;
    live_a  = id_valid_i && rf_re_i[0] && (rf_raddr_a_i != '0);
    live_b  = id_valid_i && rf_re_i[1] && (rf_raddr_b_i != '0);
    mex_a   = live_a && ex_wr && (ref_ex_waddr == rf_raddr_a_i);
    mex_b   = live_b && ex_wr && (ref_ex_waddr == rf_raddr_b_i);
    mwb_a   = live_a && wb_wr && (ref_wb_waddr == rf_raddr_a_i);
    mwb_b   = live_b && wb_wr && (ref_wb_waddr == rf_raddr_b_i);
    // JALR reads port A whatever the read enable says
    jalr_wb = wb_wr && (rf_raddr_a_i != '0) && (ref_wb_waddr == rf_raddr_a_i);
    exp_op_a_sel = mex_a ? bypass_pkg::SEL_FW_EX :
                   (mwb_a ? bypass_pkg::SEL_FW_WB : bypass_pkg::SEL_REGFILE);
    exp_op_b_sel = mex_b ? bypass_pkg::SEL_FW_EX :
                   (mwb_b ? bypass_pkg::SEL_FW_WB : bypass_pkg::SEL_REGFILE);
    exp_jalr_sel = jalr_wb ? bypass_pkg::SELJ_FW_WB : bypass_pkg::SELJ_REGFILE;
    exp_load_stall = (ref_ex_lsu && (mex_a || mex_b)) || (!wb_ready_i && (mwb_a || mwb_b));
    exp_jalr_stall = id_valid_i && id_jalr_i && (mex_a || (jalr_wb && ref_wb_lsu));
    exp_csr_stall  = id_valid_i && id_csr_en_i &&
                     ((ref_ex_valid && ref_ex_csr) || (ref_wb_valid && ref_wb_csr));
    exp_wfi_stall  = ref_ex_valid && ref_ex_wfi;
    exp_id_ready   = wb_ready_i && !exp_load_stall && !exp_jalr_stall &&
                     !exp_csr_stall && !exp_wfi_stall;
  endtask

  task automatic compare_outputs();
    check_bit("id_ready_o", id_ready_o, exp_id_ready);
    check_bit("load_stall_o", load_stall_o, exp_load_stall);
    check_bit("jalr_stall_o", jalr_stall_o, exp_jalr_stall);
    check_bit("csr_stall_o", csr_stall_o, exp_csr_stall);
    check_bit("wfi_stall_o", wfi_stall_o, exp_wfi_stall);
    check_sel("op_a_sel_o", op_a_sel_o, exp_op_a_sel);
    check_sel("op_b_sel_o", op_b_sel_o, exp_op_b_sel);
    check_bit("jalr_sel_o", jalr_sel_o, exp_jalr_sel);
  endtask

  // WB takes EX, EX takes the accepted instruction or a bubble
  task automatic advance_model(input logic accepted);
    if (wb_ready_i) begin
      ref_wb_valid = ref_ex_valid;
      ref_wb_we    = ref_ex_we;
      ref_wb_waddr = ref_ex_waddr;
      ref_wb_lsu   = ref_ex_lsu;
      ref_wb_csr   = ref_ex_csr;
      ref_ex_valid = accepted;
      ref_ex_we    = id_rf_we_i;
      ref_ex_waddr = id_rf_waddr_i;
      ref_ex_lsu   = id_lsu_en_i;
      ref_ex_csr   = id_csr_en_i;
      ref_ex_wfi   = id_wfi_i;
    end
  endtask

  // The offered instruction stays put until ID takes it
  task automatic drive_stimulus(input logic accepted);
    logic [31:0] r;
    if (accepted || !id_valid_i) begin
      rng_state = xorshift32(rng_state);
      r = rng_state;
      id_valid_i    <= (r[1:0] != 2'b00);
      rf_re_i       <= r[3:2];
      rf_raddr_a_i  <= small_addr(r[5:4]);
      rf_raddr_b_i  <= small_addr(r[7:6]);
      id_rf_we_i    <= r[8] || r[9];
      id_rf_waddr_i <= small_addr(r[11:10]);
      id_lsu_en_i   <= (r[13:12] == 2'b00);
      id_jalr_i     <= (r[16:14] == 3'b000);
      id_csr_en_i   <= (r[19:17] == 3'b000);
      id_wfi_i      <= (r[23:20] == 4'b0000);
    end
    rng_state = xorshift32(rng_state);
    // WB holds roughly one cycle in four
    wb_ready_i <= (rng_state[5:4] != 2'b00);
  endtask

  ////////////////////
  // Processes
  ////////////////////

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not complete within %0d ns", WATCHDOG_NS);
    end_with_failure();
  end

  initial begin
    logic accepted;
    reset_i       = 1'b1;
    id_valid_i    = 1'b0;
    rf_re_i       = '0;
    rf_raddr_a_i  = '0;
    rf_raddr_b_i  = '0;
    id_rf_we_i    = 1'b0;
    id_rf_waddr_i = '0;
    id_lsu_en_i   = 1'b0;
    id_jalr_i     = 1'b0;
    id_csr_en_i   = 1'b0;
    id_wfi_i      = 1'b0;
    wb_ready_i    = 1'b0;
    rng_state     = 32'd20;
    fail_count    = 0;
    accept_count  = 0;
    stall_count   = 0;
    ref_ex_valid  = 1'b0;
    ref_ex_we     = 1'b0;
    ref_ex_waddr  = '0;
    ref_ex_lsu    = 1'b0;
    ref_ex_csr    = 1'b0;
    ref_ex_wfi    = 1'b0;
    ref_wb_valid  = 1'b0;
    ref_wb_we     = 1'b0;
    ref_wb_waddr  = '0;
    ref_wb_lsu    = 1'b0;
    ref_wb_csr    = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset_i <= 1'b0;
    drive_stimulus(1'b1);
    for (int cyc = 0; cyc < TEST_CYCLES; cyc++) begin
      // Outputs are settled half a cycle after the inputs moved
      @(negedge clk);
      compute_expected();
      compare_outputs();
      if (load_stall_o || jalr_stall_o || csr_stall_o || wfi_stall_o) begin
        stall_count++;
      end
      @(posedge clk);
      accepted = id_valid_i && exp_id_ready;
      if (accepted) begin
        accept_count++;
      end
      advance_model(accepted);
      drive_stimulus(accepted);
    end
    $display("Accepted %0d instructions, %0d stall cycles", accept_count, stall_count);
    if (accept_count == 0) begin
      $display("ID never accepted an instruction during the run");
      fail_count++;
    end
    if (fail_count == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      end_with_failure();
    end
  end

endmodule

/* verilog/bypass_ctrl.sv */
`timescale 1ns/1ps

// Hazard and operand bypass controller for an ID, EX, WB pipeline
module bypass_ctrl (
  input  logic                                  clk,
  input  logic                                  reset_i,
  input  logic                                  id_valid_i,
  input  logic [bypass_pkg::NUM_READ_PORTS-1:0] rf_re_i,
  input  logic [bypass_pkg::REG_ADDR_W-1:0]     rf_raddr_a_i,
  input  logic [bypass_pkg::REG_ADDR_W-1:0]     rf_raddr_b_i,
  input  logic                                  id_rf_we_i,
  input  logic [bypass_pkg::REG_ADDR_W-1:0]     id_rf_waddr_i,
  input  logic                                  id_lsu_en_i,
  input  logic                                  id_jalr_i,
  input  logic                                  id_csr_en_i,
  input  logic                                  id_wfi_i,
  input  logic                                  wb_ready_i,
  output logic                                  id_ready_o,
  output logic                                  load_stall_o,
  output logic                                  jalr_stall_o,
  output logic                                  csr_stall_o,
  output logic                                  wfi_stall_o,
  output logic [bypass_pkg::FWD_SEL_W-1:0]      op_a_sel_o,
  output logic [bypass_pkg::FWD_SEL_W-1:0]      op_b_sel_o,
  output logic                                  jalr_sel_o
);

  // EX descriptor
  logic                                  ex_valid;
  logic                                  ex_rf_we;
  logic [bypass_pkg::REG_ADDR_W-1:0]     ex_rf_waddr;
  logic                                  ex_lsu_en;
  logic                                  ex_csr_en;
  logic                                  ex_wfi;
  // WB descriptor
  logic                                  wb_valid;
  logic                                  wb_rf_we;
  logic [bypass_pkg::REG_ADDR_W-1:0]     wb_rf_waddr;
  logic                                  wb_lsu_en;
  logic                                  wb_csr_en;
  // Matches between ID sources and older destinations
  logic [bypass_pkg::NUM_READ_PORTS-1:0] match_ex;
  logic [bypass_pkg::NUM_READ_PORTS-1:0] match_wb;
  logic                                  jalr_wb_match;
  // ID ready is also what lets stage_track load EX
  logic                                  id_ready;

  assign id_ready_o = id_ready;

  stage_track u_stage_track (
    .clk           (clk),
    .reset_i       (reset_i),
    .wb_ready_i    (wb_ready_i),
    .id_valid_i    (id_valid_i),
    .id_ready_i    (id_ready),
    .id_rf_we_i    (id_rf_we_i),
    .id_rf_waddr_i (id_rf_waddr_i),
    .id_lsu_en_i   (id_lsu_en_i),
    .id_csr_en_i   (id_csr_en_i),
    .id_wfi_i      (id_wfi_i),
    .ex_valid_o    (ex_valid),
    .ex_rf_we_o    (ex_rf_we),
    .ex_rf_waddr_o (ex_rf_waddr),
    .ex_lsu_en_o   (ex_lsu_en),
    .ex_csr_en_o   (ex_csr_en),
    .ex_wfi_o      (ex_wfi),
    .wb_valid_o    (wb_valid),
    .wb_rf_we_o    (wb_rf_we),
    .wb_rf_waddr_o (wb_rf_waddr),
    .wb_lsu_en_o   (wb_lsu_en),
    .wb_csr_en_o   (wb_csr_en)
  );

  operand_fwd u_operand_fwd (
    .id_valid_i      (id_valid_i),
    .rf_re_i         (rf_re_i),
    .rf_raddr_a_i    (rf_raddr_a_i),
    .rf_raddr_b_i    (rf_raddr_b_i),
    .ex_valid_i      (ex_valid),
    .ex_rf_we_i      (ex_rf_we),
    .ex_rf_waddr_i   (ex_rf_waddr),
    .wb_valid_i      (wb_valid),
    .wb_rf_we_i      (wb_rf_we),
    .wb_rf_waddr_i   (wb_rf_waddr),
    .match_ex_o      (match_ex),
    .match_wb_o      (match_wb),
    .jalr_wb_match_o (jalr_wb_match),
    .op_a_sel_o      (op_a_sel_o),
    .op_b_sel_o      (op_b_sel_o),
    .jalr_sel_o      (jalr_sel_o)
  );

  stall_ctrl u_stall_ctrl (
    .wb_ready_i      (wb_ready_i),
    .id_valid_i      (id_valid_i),
    .id_jalr_i       (id_jalr_i),
    .id_csr_en_i     (id_csr_en_i),
    .match_ex_i      (match_ex),
    .match_wb_i      (match_wb),
    .jalr_wb_match_i (jalr_wb_match),
    .ex_valid_i      (ex_valid),
    .ex_lsu_en_i     (ex_lsu_en),
    .ex_csr_en_i     (ex_csr_en),
    .ex_wfi_i        (ex_wfi),
    .wb_valid_i      (wb_valid),
    .wb_lsu_en_i     (wb_lsu_en),
    .wb_csr_en_i     (wb_csr_en),
    .load_stall_o    (load_stall_o),
    .jalr_stall_o    (jalr_stall_o),
    .csr_stall_o     (csr_stall_o),
    .wfi_stall_o     (wfi_stall_o),
    .id_ready_o      (id_ready)
  );

endmodule

/* verilog/bypass_pkg.sv */
////////////////////
// Shared widths and encodings for the hazard and bypass controller
////////////////////

package bypass_pkg;

  // Register file addressing, 32 architectural registers
  localparam int unsigned REG_ADDR_W = 5;

  // ID reads at most two source registers per instruction
  localparam int unsigned NUM_READ_PORTS = 2;

  // Width of the operand A and B forward mux selects
  localparam int unsigned FWD_SEL_W = 2;

  // Operand mux codes, code 3 is left unused on purpose
  localparam logic [FWD_SEL_W-1:0] SEL_REGFILE = 2'd0;
  localparam logic [FWD_SEL_W-1:0] SEL_FW_EX   = 2'd1;
  localparam logic [FWD_SEL_W-1:0] SEL_FW_WB   = 2'd2;

  // Jump register path has only two sources
  // EX results never reach the JALR target adder directly
  localparam logic SELJ_REGFILE = 1'b0;
  localparam logic SELJ_FW_WB   = 1'b1;

endpackage

/* verilog/operand_fwd.sv */
`timescale 1ns/1ps

// Source register matching against EX and WB, plus the forward mux selects
module operand_fwd (
  input  logic                                  id_valid_i,
  input  logic [bypass_pkg::NUM_READ_PORTS-1:0] rf_re_i,
  input  logic [bypass_pkg::REG_ADDR_W-1:0]     rf_raddr_a_i,
  input  logic [bypass_pkg::REG_ADDR_W-1:0]     rf_raddr_b_i,
  input  logic                                  ex_valid_i,
  input  logic                                  ex_rf_we_i,
  input  logic [bypass_pkg::REG_ADDR_W-1:0]     ex_rf_waddr_i,
  input  logic                                  wb_valid_i,
  input  logic                                  wb_rf_we_i,
  input  logic [bypass_pkg::REG_ADDR_W-1:0]     wb_rf_waddr_i,
  output logic [bypass_pkg::NUM_READ_PORTS-1:0] match_ex_o,
  output logic [bypass_pkg::NUM_READ_PORTS-1:0] match_wb_o,
  output logic                                  jalr_wb_match_o,
  output logic [bypass_pkg::FWD_SEL_W-1:0]      op_a_sel_o,
  output logic [bypass_pkg::FWD_SEL_W-1:0]      op_b_sel_o,
  output logic                                  jalr_sel_o
);

  // Read addresses gathered so the match logic can be generated per port
  logic [bypass_pkg::REG_ADDR_W-1:0] rf_raddr [bypass_pkg::NUM_READ_PORTS];

  // Stage is actually going to write the register file
  logic ex_writes;
  logic wb_writes;

  // Younger producer wins, EX holds the newer value than WB
  function automatic logic [bypass_pkg::FWD_SEL_W-1:0] pick_sel(
    input logic hit_ex,
    input logic hit_wb
  );
    logic [bypass_pkg::FWD_SEL_W-1:0] sel;
    sel = bypass_pkg::SEL_REGFILE;
    if (hit_ex) begin
      sel = bypass_pkg::SEL_FW_EX;
    end else if (hit_wb) begin
      sel = bypass_pkg::SEL_FW_WB;
    end
    return sel;
  endfunction

  assign rf_raddr[0] = rf_raddr_a_i;
  assign rf_raddr[1] = rf_raddr_b_i;

  assign ex_writes = ex_valid_i && ex_rf_we_i;
  assign wb_writes = wb_valid_i && wb_rf_we_i;

  ////////////////////
  // Per port matching
  ////////////////////

  // x0 reads as zero and is never a hazard, so nonzero addresses only
  for (genvar p = 0; p < bypass_pkg::NUM_READ_PORTS; p++) begin : gen_port_match
    logic port_live;
    assign port_live     = id_valid_i && rf_re_i[p] && (|rf_raddr[p]);
    assign match_ex_o[p] = port_live && ex_writes && (ex_rf_waddr_i == rf_raddr[p]);
    assign match_wb_o[p] = port_live && wb_writes && (wb_rf_waddr_i == rf_raddr[p]);
  end

  assign op_a_sel_o = pick_sel(match_ex_o[0], match_wb_o[0]);
  assign op_b_sel_o = pick_sel(match_ex_o[1], match_wb_o[1]);

  // JALR always reads rs1 on port A, the read enable is implied here
  // Also left unqualified by ID valid, the select is ignored without a JALR
  assign jalr_wb_match_o = wb_writes && (|rf_raddr_a_i) && (wb_rf_waddr_i == rf_raddr_a_i);

  assign jalr_sel_o = jalr_wb_match_o ? bypass_pkg::SELJ_FW_WB : bypass_pkg::SELJ_REGFILE;

endmodule

/* verilog/stage_track.sv */
`timescale 1ns/1ps

// Keeps a copy of what sits in EX and WB so the hazard logic can look at it
// Only the fields that matter for stalls and forwarding are tracked
module stage_track (
  input  logic                              clk,
  input  logic                              reset_i,
  input  logic                              wb_ready_i,
  input  logic                              id_valid_i,
  input  logic                              id_ready_i,
  input  logic                              id_rf_we_i,
  input  logic [bypass_pkg::REG_ADDR_W-1:0] id_rf_waddr_i,
  input  logic                              id_lsu_en_i,
  input  logic                              id_csr_en_i,
  input  logic                              id_wfi_i,
  output logic                              ex_valid_o,
  output logic                              ex_rf_we_o,
  output logic [bypass_pkg::REG_ADDR_W-1:0] ex_rf_waddr_o,
  output logic                              ex_lsu_en_o,
  output logic                              ex_csr_en_o,
  output logic                              ex_wfi_o,
  output logic                              wb_valid_o,
  output logic                              wb_rf_we_o,
  output logic [bypass_pkg::REG_ADDR_W-1:0] wb_rf_waddr_o,
  output logic                              wb_lsu_en_o,
  output logic                              wb_csr_en_o
);

  // The pipeline moves only when WB retires its instruction
  logic advance;
  // Handshake completes in ID this cycle
  logic id_accept;

  assign advance   = wb_ready_i;
  assign id_accept = id_valid_i && id_ready_i;

  ////////////////////
  // Valid bits
  ////////////////////

  // On an advance WB inherits EX, and EX gets either the accepted
  // instruction or a bubble when ID did not hand anything over
  always_ff @(posedge clk) begin
    if (reset_i) begin
      ex_valid_o <= 1'b0;
      wb_valid_o <= 1'b0;
    end else if (advance) begin
      wb_valid_o <= ex_valid_o;
      ex_valid_o <= id_accept;
    end
  end

  ////////////////////
  // Descriptor payload
  ////////////////////

  // Fields are don't care while the matching valid bit is low
  // All consumers qualify them with valid
  always_ff @(posedge clk) begin
    if (advance) begin
      ex_rf_we_o    <= id_rf_we_i;
      ex_rf_waddr_o <= id_rf_waddr_i;
      ex_lsu_en_o   <= id_lsu_en_i;
      ex_csr_en_o   <= id_csr_en_i;
      ex_wfi_o      <= id_wfi_i;
      // WFI only blocks ID while in EX, so WB never needs it
      wb_rf_we_o    <= ex_rf_we_o;
      wb_rf_waddr_o <= ex_rf_waddr_o;
      wb_lsu_en_o   <= ex_lsu_en_o;
      wb_csr_en_o   <= ex_csr_en_o;
    end
  end

endmodule

/* verilog/stall_ctrl.sv */
`timescale 1ns/1ps

// Turns the register matches and stage flags into ID stalls
module stall_ctrl (
  input  logic                                  wb_ready_i,
  input  logic                                  id_valid_i,
  input  logic                                  id_jalr_i,
  input  logic                                  id_csr_en_i,
  input  logic [bypass_pkg::NUM_READ_PORTS-1:0] match_ex_i,
  input  logic [bypass_pkg::NUM_READ_PORTS-1:0] match_wb_i,
  input  logic                                  jalr_wb_match_i,
  input  logic                                  ex_valid_i,
  input  logic                                  ex_lsu_en_i,
  input  logic                                  ex_csr_en_i,
  input  logic                                  ex_wfi_i,
  input  logic                                  wb_valid_i,
  input  logic                                  wb_lsu_en_i,
  input  logic                                  wb_csr_en_i,
  output logic                                  load_stall_o,
  output logic                                  jalr_stall_o,
  output logic                                  csr_stall_o,
  output logic                                  wfi_stall_o,
  output logic                                  id_ready_o
);

  // A CSR access sits in EX or WB and may still change CSR state
  logic csr_in_flight;

  ////////////////////
  // Stall sources
  ////////////////////

  // Load data is not available from EX at all, and from WB only once
  // the data bus has answered, which wb_ready_i tells us
  assign load_stall_o = (ex_lsu_en_i && (|match_ex_i)) ||
                        (!wb_ready_i && (|match_wb_i));

  // The jump target adder only taps WB, and never load data from WB
  assign jalr_stall_o = id_valid_i && id_jalr_i &&
                        (match_ex_i[0] || (jalr_wb_match_i && wb_lsu_en_i));

  assign csr_in_flight = (ex_valid_i && ex_csr_en_i) || (wb_valid_i && wb_csr_en_i);

  // Coarse rule: any CSR in ID waits for older CSR accesses to drain
  assign csr_stall_o = id_valid_i && id_csr_en_i && csr_in_flight;

  // Nothing may follow a WFI until it has left EX
  assign wfi_stall_o = ex_valid_i && ex_wfi_i;

  ////////////////////
  // ID handshake
  ////////////////////

  // Back-pressure from WB blocks ID just like any stall does
  assign id_ready_o = wb_ready_i && !load_stall_o && !jalr_stall_o &&
                      !csr_stall_o && !wfi_stall_o;

endmodule
